// ==== include/life_consts.svh ====
// Board geometry and APB register map shared by the RTL and the testbench
// LIFE_DEPTH must equal 2**LIFE_ROW_BITS because row addresses wrap by truncation
`ifndef LIFE_CONSTS_SVH
`define LIFE_CONSTS_SVH

////////////////////
// Board
`define LIFE_WIDTH     16   // Cells per row
`define LIFE_DEPTH     16   // Rows per board
`define LIFE_ROW_BITS  4    // Row index bits
`define LIFE_GENS      2    // Generation stages in the chain

// Rows read per pass with GENS rows of wrap margin on each edge
`define LIFE_PASS_ROWS (`LIFE_DEPTH + 2 * `LIFE_GENS)

////////////////////
// APB word addresses
`define APB_ROW_BASE   8'h00  // Row 0, the other rows follow
`define APB_CTRL       8'h40  // Pass command
`define APB_STATUS     8'h44  // Busy in bit 0
`define APB_GEN_COUNT  8'h48  // Total generations

`endif

// ==== src/life_pkg.sv ====
// Types for the cell board, sized from the shared constants
// A RAM address holds the board select bit above the row index
`include "life_consts.svh"

package life_pkg;

	// One row of cells, bit i is column i
	typedef logic [`LIFE_WIDTH-1:0] row_t;

	// Row index within one board
	typedef logic [`LIFE_ROW_BITS-1:0] row_addr_t;

	// Board select in the MSB
	typedef logic [`LIFE_ROW_BITS:0] ram_addr_t;

	// Total generations since reset
	typedef logic [31:0] gen_count_t;

endpackage

// ==== src/apb_pkg.sv ====
// Types for the APB side of the design
// Addresses are word addresses
package apb_pkg;

	typedef logic [7:0]  apb_addr_t;  // Word address
	typedef logic [31:0] apb_data_t;  // Read and write data

	// Register selected by the decoded address
	typedef enum logic [2:0] {
		ROW,        // Board row window
		CTRL,       // Pass command
		STATUS,     // Busy flag
		GEN_COUNT,  // Generation count
		BAD         // Unmapped
	} reg_sel_t;

endpackage

// ==== src/cell_ram.sv ====
// Two boards in one array with the board select as address MSB
// Registered read with one cycle latency, no reset on the contents
`include "life_consts.svh"

module cell_ram (
	input  logic                clk,
	input  life_pkg::ram_addr_t raddr,
	output life_pkg::row_t      rdata,
	input  life_pkg::ram_addr_t waddr,
	input  logic                we,
	input  life_pkg::row_t      wdata
);

	// Board 0 in the low half, board 1 in the high half
	life_pkg::row_t mem [2 * `LIFE_DEPTH];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr];  // Old row if the same address is written
	end

endmodule

// ==== src/gen_stage.sv ====
// One generation of the torus rule applied to a stream of rows
// Output lags the input by one row and one cycle
`include "life_consts.svh"

module gen_stage (
	input  logic           clk,
	input  logic           reset,
	input  logic           shift,
	input  life_pkg::row_t row_in,
	output life_pkg::row_t row_out
);

	localparam int W = `LIFE_WIDTH;

	life_pkg::row_t win [2];   // [0] newest row, [1] oldest and middle after a shift
	logic [1:0] col_sum [W];   // Three-row sum per column
	logic [1:0] sum_q   [W];   // Sums of the window around the middle row
	logic [3:0] nine    [W];   // Nine-cell sum, cell itself included

	// Window is win[1], win[0] and the incoming row
	always_comb begin
		for (int i = 0; i < W; i++) begin
			col_sum[i] = {1'b0, win[1][i]} + {1'b0, win[0][i]} + {1'b0, row_in[i]};
		end
	end

	////////////////////
	// Window shift
	always_ff @(posedge clk) begin
		if (reset) begin
			win[0] <= '0;
			win[1] <= '0;
			sum_q  <= '{default: '0};
		end else if (shift) begin
			win[1] <= win[0];   // Becomes the middle row
			win[0] <= row_in;
			sum_q  <= col_sum;
		end
	end

	////////////////////
	// Rule with wrapped columns
	always_comb begin
		for (int i = 0; i < W; i++) begin
			nine[i] = {2'b00, sum_q[(i + W - 1) % W]}
				+ {2'b00, sum_q[i]}
				+ {2'b00, sum_q[(i + 1) % W]};
			// Three is birth or survival, four keeps a live cell
			row_out[i] = (nine[i] == 4'd3) || ((nine[i] == 4'd4) && win[1][i]);
		end
	end

endmodule

// ==== src/life_engine.sv ====
// Cell RAM, the chain of generation stages and the write-back register
// Host strobes must only be raised while the sequencer is idle
`include "life_consts.svh"

module life_engine (
	input  logic                clk,
	input  logic                reset,
	input  logic                shift,
	input  logic                board,
	input  life_pkg::row_addr_t raddr,
	input  life_pkg::row_addr_t waddr,
	input  logic                we,
	input  logic                host_we,
	input  logic                host_re,
	input  life_pkg::row_addr_t host_addr,
	input  life_pkg::row_t      host_wdata,
	output life_pkg::row_t      host_rdata
);

	life_pkg::ram_addr_t ram_raddr;
	life_pkg::ram_addr_t ram_waddr;
	life_pkg::row_t      ram_rdata;
	life_pkg::row_t      ram_wdata;
	life_pkg::row_t      stage_row [`LIFE_GENS + 1];  // [0] from RAM, last is newest generation
	life_pkg::row_t      wb_row;                      // Row waiting for write-back

	// Reads always hit the current board
	assign ram_raddr = {board, (host_re ? host_addr : raddr)};
	// Host writes the current board, a pass fills the other one
	assign ram_waddr = host_we ? {board, host_addr} : {~board, waddr};
	assign ram_wdata = host_we ? host_wdata : wb_row;

	cell_ram cell_ram_i (
		.clk   (clk),
		.raddr (ram_raddr),
		.rdata (ram_rdata),
		.waddr (ram_waddr),
		.we    (we | host_we),
		.wdata (ram_wdata)
	);

	assign stage_row[0] = ram_rdata;
	assign host_rdata   = ram_rdata;  // Valid the cycle after host_re

	for (genvar g = 0; g < `LIFE_GENS; g++) begin : g_stage
		gen_stage gen_stage_i (
			.clk     (clk),
			.reset   (reset),
			.shift   (shift),
			.row_in  (stage_row[g]),
			.row_out (stage_row[g + 1])
		);
	end

	always_ff @(posedge clk) begin
		if (shift) begin
			wb_row <= stage_row[`LIFE_GENS];
		end
	end

endmodule

// ==== src/life_sequencer.sv ====
// Drives back to back passes over the board, each worth LIFE_GENS generations
// Start is ignored while busy or with a zero pass count
`include "life_consts.svh"

module life_sequencer (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 start,
	input  apb_pkg::apb_data_t   pass_count,
	output logic                 busy,
	output logic                 board,
	output life_pkg::row_addr_t  raddr,
	output life_pkg::row_addr_t  waddr,
	output logic                 we,
	output logic                 shift,
	output life_pkg::gen_count_t gen_count
);

	// Read issue to write cycle. RAM read, one per stage, write-back
	localparam int PIPE     = `LIFE_GENS + 2;
	localparam int PASS_LEN = `LIFE_PASS_ROWS + PIPE;
	localparam int FIRST_WR = PIPE + 2 * `LIFE_GENS;  // Every stage window full
	localparam int CNT_BITS = $clog2(PASS_LEN);

	logic [CNT_BITS-1:0] cnt;         // Cycle within the pass
	apb_pkg::apb_data_t  remaining;   // Passes left, current one included
	logic                last_cycle;  // Final write of the pass

	assign last_cycle = (cnt == CNT_BITS'(PASS_LEN - 1));

	////////////////////
	// Pass control
	always_ff @(posedge clk) begin
		if (reset) begin
			busy      <= 1'b0;
			board     <= 1'b0;
			cnt       <= '0;
			remaining <= '0;
			gen_count <= '0;
		end else if (!busy) begin
			if (start && (pass_count != '0)) begin
				busy      <= 1'b1;
				remaining <= pass_count;
				cnt       <= '0;
			end
		end else if (last_cycle) begin
			gen_count <= gen_count + life_pkg::gen_count_t'(`LIFE_GENS);
			board     <= ~board;  // New generation becomes current
			remaining <= remaining - 1'b1;
			cnt       <= '0;
			if (remaining == apb_pkg::apb_data_t'(1)) begin
				busy <= 1'b0;
			end
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	////////////////////
	// RAM and stage strobes
	// Reads start GENS rows above row 0 and wrap
	assign raddr = life_pkg::row_addr_t'(cnt - `LIFE_GENS);
	assign waddr = life_pkg::row_addr_t'(cnt - FIRST_WR);  // Row 0 on the first write
	assign we    = busy && (cnt >= CNT_BITS'(FIRST_WR));
	assign shift = busy;  // Stages run every cycle of a pass

endmodule

// ==== src/life_apb_regs.sv ====
// APB slave for board rows, the pass command and status
// A row read adds one wait state, board access and CTRL writes are refused while busy
`include "life_consts.svh"

module life_apb_regs (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  apb_pkg::apb_addr_t   paddr,
	input  apb_pkg::apb_data_t   pwdata,
	output apb_pkg::apb_data_t   prdata,
	output logic                 pready,
	output logic                 pslverr,
	input  logic                 busy,
	input  life_pkg::gen_count_t gen_count,
	output logic                 start,
	output apb_pkg::apb_data_t   pass_count,
	output logic                 host_we,
	output logic                 host_re,
	output life_pkg::row_addr_t  host_addr,
	output life_pkg::row_t       host_wdata,
	input  life_pkg::row_t       host_rdata
);

	apb_pkg::reg_sel_t  sel;
	apb_pkg::apb_addr_t row_off;  // Offset from row 0
	logic access;                 // Access phase
	logic err;                    // Refused transfer
	logic row_rd;                 // Accepted row read
	logic ctrl_wr;                // Accepted pass command
	logic rd_wait;                // Second access cycle of a row read

	////////////////////
	// Address decode
	assign row_off = paddr - `APB_ROW_BASE;

	always_comb begin
		if (row_off < apb_pkg::apb_addr_t'(`LIFE_DEPTH)) begin
			sel = apb_pkg::ROW;
		end else begin
			case (paddr)
				`APB_CTRL:      sel = apb_pkg::CTRL;
				`APB_STATUS:    sel = apb_pkg::STATUS;
				`APB_GEN_COUNT: sel = apb_pkg::GEN_COUNT;
				default:        sel = apb_pkg::BAD;
			endcase
		end
	end

	assign access = psel && penable;
	assign err = (sel == apb_pkg::BAD)
		|| (busy && (sel == apb_pkg::ROW))
		|| (busy && (sel == apb_pkg::CTRL) && pwrite);

	assign row_rd  = (sel == apb_pkg::ROW) && !pwrite && !err;
	assign ctrl_wr = access && pwrite && (sel == apb_pkg::CTRL) && !err;

	////////////////////
	// Handshake
	assign pready  = access && (!row_rd || rd_wait);  // Row read waits one cycle
	assign pslverr = pready && err;

	// Host row port, current board only
	assign host_re    = access && row_rd && !rd_wait;  // Address goes out in the first cycle
	assign host_we    = access && pwrite && (sel == apb_pkg::ROW) && !err;
	assign host_addr  = life_pkg::row_addr_t'(row_off);
	assign host_wdata = life_pkg::row_t'(pwdata);

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_wait    <= 1'b0;
			start      <= 1'b0;
			pass_count <= '0;
		end else begin
			rd_wait <= host_re;
			start   <= ctrl_wr;  // Sequencer sees start with the new count
			if (ctrl_wr) begin
				pass_count <= pwdata;
			end
		end
	end

	// Read data only on a completing read that is not refused
	always_comb begin
		prdata = '0;
		if (pready && !pwrite && !err) begin
			case (sel)
				apb_pkg::ROW:       prdata = apb_pkg::apb_data_t'(host_rdata);
				apb_pkg::CTRL:      prdata = pass_count;  // Last command written
				apb_pkg::STATUS:    prdata = apb_pkg::apb_data_t'(busy);
				apb_pkg::GEN_COUNT: prdata = apb_pkg::apb_data_t'(gen_count);
				default:            prdata = '0;
			endcase
		end
	end

endmodule

// ==== src/life_top.sv ====
// Life engine reached over APB
// The host seeds and reads the board only while no pass runs
module life_top (
	input  logic               clk,
	input  logic               reset,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  apb_pkg::apb_addr_t paddr,
	input  apb_pkg::apb_data_t pwdata,
	output apb_pkg::apb_data_t prdata,
	output logic               pready,
	output logic               pslverr
);

	// Sequencer to register block
	logic                 busy;
	life_pkg::gen_count_t gen_count;
	logic                 start;
	apb_pkg::apb_data_t   pass_count;

	// Host row port
	logic                 host_we;
	logic                 host_re;
	life_pkg::row_addr_t  host_addr;
	life_pkg::row_t       host_wdata;
	life_pkg::row_t       host_rdata;

	// Sequencer to engine
	logic                 board;
	life_pkg::row_addr_t  raddr;
	life_pkg::row_addr_t  waddr;
	logic                 we;
	logic                 shift;

	life_apb_regs life_apb_regs_i (
		.clk        (clk),
		.reset      (reset),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.busy       (busy),
		.gen_count  (gen_count),
		.start      (start),
		.pass_count (pass_count),
		.host_we    (host_we),
		.host_re    (host_re),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata)
	);

	life_sequencer life_sequencer_i (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.pass_count (pass_count),
		.busy       (busy),
		.board      (board),
		.raddr      (raddr),
		.waddr      (waddr),
		.we         (we),
		.shift      (shift),
		.gen_count  (gen_count)
	);

	life_engine life_engine_i (
		.clk        (clk),
		.reset      (reset),
		.shift      (shift),
		.board      (board),
		.raddr      (raddr),
		.waddr      (waddr),
		.we         (we),
		.host_we    (host_we),
		.host_re    (host_re),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata)
	);

endmodule

// ==== test/tb_clock.sv ====
// Free running clock with a 20 ns period
// Reset is held high for the first 5 rising edges
module tb_clock (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;  // 20 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clk);
		reset <= 1'b0;  // Released on the 5th edge
	end

endmodule

// ==== test/life_tb.sv ====
// Drives the life engine over APB and compares every board with a torus model
// Rows are word addressed from APB_ROW_BASE, one transfer per row
`include "life_consts.svh"

module life_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int W = `LIFE_WIDTH;
	localparam int D = `LIFE_DEPTH;
	localparam int TIMEOUT = 40 * 40 + 2000;  // 40 passes of 40 cycles plus bus traffic

	logic               clk;
	logic               reset;
	logic               psel;
	logic               penable;
	logic               pwrite;
	apb_pkg::apb_addr_t paddr;
	apb_pkg::apb_data_t pwdata;
	apb_pkg::apb_data_t prdata;
	logic               pready;
	logic               pslverr;

	logic [W-1:0] model [D];         // Expected board
	logic [31:0]  lcg_state = 32'h7c24;
	int value_errors    = 0;
	int protocol_errors = 0;
	int cycles          = 0;
	int total_passes    = 0;         // Passes run since reset

	tb_clock tb_clock_i (.clk(clk), .reset(reset));

	life_top dut_i (
		.clk     (clk),
		.reset   (reset),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	////////////////////
	// APB protocol
	pready_in_access: assert property (@(posedge clk) disable iff (reset)
		pready |-> (psel && penable)) else begin
		protocol_errors++;
		$display("[ERROR] %0t: pready outside an access cycle", $time);
	end

	pslverr_with_pready: assert property (@(posedge clk) disable iff (reset)
		pslverr |-> pready) else begin
		protocol_errors++;
		$display("[ERROR] %0t: pslverr without pready", $time);
	end

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
			$display("Done: errors found");
			$finish;
		end
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	////////////////////
	// Bus tasks
	task automatic apb_xfer(input logic write, input apb_pkg::apb_addr_t addr,
			input apb_pkg::apb_data_t wdata, output apb_pkg::apb_data_t rdata,
			output logic err, output int waits);
		@(posedge clk);
		psel    <= 1'b1;  // Setup cycle
		pwrite  <= write;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);   // Mid cycle, outputs settled
		waits = 0;
		while (!pready) begin
			waits++;
			@(negedge clk);
		end
		rdata   = prdata;
		err     = pslverr;
		@(posedge clk);   // Transfer completes on this edge
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic write_reg(input apb_pkg::apb_addr_t addr, input apb_pkg::apb_data_t data,
			input logic exp_err, input string what);
		apb_pkg::apb_data_t rdata;
		logic err;
		int waits;
		apb_xfer(1'b1, addr, data, rdata, err, waits);
		assert (err == exp_err) else begin
			value_errors++;
			$display("[ERROR] %0t: %s got pslverr %0b, expected %0b", $time, what, err, exp_err);
		end
	endtask

	task automatic check_read(input apb_pkg::apb_addr_t addr, input apb_pkg::apb_data_t exp,
			input string what);
		apb_pkg::apb_data_t rdata;
		logic err;
		int waits;
		apb_xfer(1'b0, addr, '0, rdata, err, waits);
		assert (!err && (rdata == exp)) else begin
			value_errors++;
			$display("[ERROR] %0t: %s read 0x%0h err %0b, expected 0x%0h", $time, what, rdata,
				err, exp);
		end
		// Only row reads carry the wait state
		assert (waits == ((addr < D) ? 1 : 0)) else begin
			value_errors++;
			$display("[ERROR] %0t: %s took %0d wait states", $time, what, waits);
		end
	endtask

	task automatic read_refused(input apb_pkg::apb_addr_t addr, input string what);
		apb_pkg::apb_data_t rdata;
		logic err;
		int waits;
		apb_xfer(1'b0, addr, '0, rdata, err, waits);
		assert (err) else begin
			value_errors++;
			$display("[ERROR] %0t: %s was not refused", $time, what);
		end
	endtask

	////////////////////
	// Reference model, plain eight-neighbor count on a torus
	task automatic step_model();
		logic [W-1:0] cur [D];
		int n;
		cur = model;
		for (int r = 0; r < D; r++) begin
			for (int c = 0; c < W; c++) begin
				n = 0;
				for (int dr = -1; dr <= 1; dr++) begin
					for (int dc = -1; dc <= 1; dc++) begin
						if ((dr != 0) || (dc != 0)) begin
							n += int'(cur[(r + dr + D) % D][(c + dc + W) % W]);
						end
					end
				end
				model[r][c] = (n == 3) || ((n == 2) && cur[r][c]);  // Birth, survival
			end
		end
	endtask

	task automatic fill_random();
		logic [31:0] rnd;
		for (int r = 0; r < D; r++) begin
			rnd = next_random();
			model[r] = W'(rnd >> 16);  // Upper bits are the better ones
		end
	endtask

	task automatic load_board();
		for (int r = 0; r < D; r++) begin
			write_reg(apb_pkg::apb_addr_t'(`APB_ROW_BASE + r), apb_pkg::apb_data_t'(model[r]),
				1'b0, "row write");
		end
	endtask

	task automatic check_board(input string what);
		for (int r = 0; r < D; r++) begin
			check_read(apb_pkg::apb_addr_t'(`APB_ROW_BASE + r), apb_pkg::apb_data_t'(model[r]),
				what);
		end
	endtask

	// Poll STATUS until the sequencer is idle again
	task automatic wait_idle();
		apb_pkg::apb_data_t status;
		logic err;
		int waits;
		do begin
			apb_xfer(1'b0, `APB_STATUS, '0, status, err, waits);
		end while (status[0]);
	endtask

	task automatic advance_model(input int passes);
		for (int i = 0; i < passes * `LIFE_GENS; i++) begin
			step_model();
		end
		total_passes += passes;
	endtask

	task automatic run_passes(input int passes);
		write_reg(`APB_CTRL, apb_pkg::apb_data_t'(passes), 1'b0, "CTRL write");
		wait_idle();
		advance_model(passes);
	endtask

	////////////////////
	// Stimulus
	initial begin
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		@(posedge clk);
		while (reset) @(posedge clk);

		check_read(`APB_STATUS, 32'd0, "STATUS after reset");
		check_read(`APB_GEN_COUNT, 32'd0, "GEN_COUNT after reset");

		fill_random();
		load_board();
		check_board("random row");

		// Blinker, block, and a glider over the corner
		model = '{default: '0};
		model[5]  = 16'h00E0;
		model[10] = 16'h0C00;
		model[11] = 16'h0C00;
		model[15] = 16'h8000;
		model[0]  = 16'h0001;
		model[1]  = 16'hC001;
		load_board();
		run_passes(1);
		check_board("pattern row after one pass");

		fill_random();
		load_board();
		run_passes(5);
		check_board("random row after five passes");
		check_read(`APB_GEN_COUNT, apb_pkg::apb_data_t'(total_passes * `LIFE_GENS), "GEN_COUNT");

		// Refused while busy
		write_reg(`APB_CTRL, 32'd3, 1'b0, "CTRL write");
		write_reg(`APB_ROW_BASE + 8'd2, 32'hffff, 1'b1, "row write while busy");
		read_refused(`APB_ROW_BASE + 8'd5, "row read while busy");
		write_reg(`APB_CTRL, 32'd7, 1'b1, "CTRL write while busy");
		wait_idle();
		advance_model(3);
		check_board("row after refused transfers");

		write_reg(8'h4C, 32'd5, 1'b1, "write to unmapped address");
		write_reg(`APB_ROW_BASE + 8'd16, 32'hffff, 1'b1, "write past the last row");
		read_refused(8'h80, "read of unmapped address");
		check_read(`APB_CTRL, 32'd3, "CTRL after unmapped writes");
		check_read(`APB_STATUS, 32'd0, "STATUS after unmapped writes");
		check_read(`APB_GEN_COUNT, apb_pkg::apb_data_t'(total_passes * `LIFE_GENS), "GEN_COUNT");
		check_board("row after unmapped writes");

		$display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
		if ((value_errors == 0) && (protocol_errors == 0)) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+include
src/life_pkg.sv
src/apb_pkg.sv
src/cell_ram.sv
src/gen_stage.sv
src/life_engine.sv
src/life_sequencer.sv
src/life_apb_regs.sv
src/life_top.sv
test/tb_clock.sv
test/life_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = life_tb
FILELIST = project.f
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
